// File: design/fpadd_pkg.sv
// Floating-point adder shared definitions
`default_nettype none

package fpadd_pkg;

  // Default format is binary32
  localparam int unsigned EXP_BITS = 8;   // Exponent field width
  localparam int unsigned MAN_BITS = 23;  // Fraction field width, hidden bit excluded

  // Rounding modes, RISC-V frm encoding
  typedef enum logic [2:0] {
    RNE = 3'b000,  // Nearest, ties to even
    RTZ = 3'b001,  // Toward zero
    RDN = 3'b010,  // Toward -inf
    RUP = 3'b011,  // Toward +inf
    RMM = 3'b100   // Nearest, ties away from zero
  } roundmode_e;

  // Operand classification
  typedef struct packed {
    logic is_zero;
    logic is_inf;
    logic is_nan;        // Quiet or signalling
    logic is_snan;       // Signalling only
    logic is_subnormal;
  } fp_class_t;

  // Exception flags, fflags order without DZ
  typedef struct packed {
    logic nv;  // Invalid operation
    logic of;  // Overflow
    logic uf;  // Underflow
    logic nx;  // Inexact
  } status_t;

  // Exponent bias of the format
  function automatic int unsigned bias(int unsigned exp_bits);
    return (1 << (exp_bits - 1)) - 1;
  endfunction

  // Canonical quiet NaN, positive, MSB of fraction set
  // Wide enough for binary64, callers take the low bits
  function automatic logic [63:0] qnan_pattern(int unsigned exp_bits,
                                               int unsigned man_bits);
    logic [63:0] exp_ones;
    exp_ones = (64'd1 << exp_bits) - 64'd1;
    return (exp_ones << man_bits) | (64'd1 << (man_bits - 1));
  endfunction

endpackage

`default_nettype wire

// File: design/fpadd_sum_if.sv
// Aligned sum bundle between stages
`default_nettype none

interface fpadd_sum_if #(
  parameter int unsigned ExpBits = fpadd_pkg::EXP_BITS,
  parameter int unsigned ManBits = fpadd_pkg::MAN_BITS
) ();
  import fpadd_pkg::*;

  logic                           valid;
  logic                           sign;           // Sign of the larger operand
  logic signed [ExpBits+1:0]      exponent;       // Larger exponent, subnormal as 1
  logic        [ManBits+3:0]      significand;    // {carry, hidden, fraction, guard, round}
  logic                           sticky;
  logic                           eff_sub;        // Operand signs differed
  logic                           special;        // NaN or infinity result
  logic        [ExpBits+ManBits:0] special_value;
  logic                           invalid;
  roundmode_e                     rnd_mode;

  modport src (output valid, sign, exponent, significand, sticky, eff_sub,
                      special, special_value, invalid, rnd_mode);
  modport dst (input  valid, sign, exponent, significand, sticky, eff_sub,
                      special, special_value, invalid, rnd_mode);

endinterface

`default_nettype wire

// File: design/fpadd_classify.sv
// Operand field split and classification
`default_nettype none

module fpadd_classify #(
  parameter int unsigned ExpBits = fpadd_pkg::EXP_BITS,
  parameter int unsigned ManBits = fpadd_pkg::MAN_BITS
) (
  input  logic [ExpBits+ManBits:0] operand_i,
  output logic                     sign_o,
  output logic [ExpBits-1:0]       exponent_o,     // Subnormals map to 1
  output logic [ManBits:0]         significand_o,  // Hidden bit included
  output fpadd_pkg::fp_class_t     class_o
);

  logic [ExpBits-1:0] exp_field;
  logic [ManBits-1:0] frac_field;
  logic               exp_zero;
  logic               exp_ones;
  logic               frac_zero;

  assign sign_o     = operand_i[ExpBits+ManBits];
  assign exp_field  = operand_i[ExpBits+ManBits-1:ManBits];
  assign frac_field = operand_i[ManBits-1:0];

  assign exp_zero  = (exp_field == '0);
  assign exp_ones  = &exp_field;
  assign frac_zero = (frac_field == '0);

  // Subnormals share the scale of the smallest normal
  assign exponent_o    = exp_zero ? ExpBits'(1) : exp_field;
  assign significand_o = {~exp_zero, frac_field};  // Hidden bit only for normals

  assign class_o.is_zero      = exp_zero & frac_zero;
  assign class_o.is_inf       = exp_ones & frac_zero;
  assign class_o.is_nan       = exp_ones & ~frac_zero;
  assign class_o.is_snan      = exp_ones & ~frac_zero & ~frac_field[ManBits-1];  // Quiet bit clear
  assign class_o.is_subnormal = exp_zero & ~frac_zero;

endmodule

`default_nettype wire

// File: design/fpadd_align_add.sv
// Stage 1 alignment and significand add
`default_nettype none

module fpadd_align_add #(
  parameter int unsigned ExpBits = fpadd_pkg::EXP_BITS,
  parameter int unsigned ManBits = fpadd_pkg::MAN_BITS
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  valid_i,
  input  logic                  sub_i,
  input  fpadd_pkg::roundmode_e rnd_mode_i,
  input  logic                  a_sign_i,
  input  logic [ExpBits-1:0]    a_exp_i,
  input  logic [ManBits:0]      a_sig_i,
  input  fpadd_pkg::fp_class_t  a_class_i,
  input  logic                  b_sign_i,
  input  logic [ExpBits-1:0]    b_exp_i,
  input  logic [ManBits:0]      b_sig_i,
  input  fpadd_pkg::fp_class_t  b_class_i,
  fpadd_sum_if.src              sum_o
);
  import fpadd_pkg::*;

  localparam int unsigned SigW = ManBits + 3;  // Hidden, fraction, guard, round
  localparam int unsigned W    = ExpBits + ManBits + 1;
  localparam logic [63:0] QNanWide = qnan_pattern(ExpBits, ManBits);

  logic               b_sign_eff;
  logic               eff_sub;
  logic               a_larger;
  logic               big_sign;
  logic [ExpBits-1:0] big_exp;
  logic [ExpBits-1:0] small_exp;
  logic [ExpBits-1:0] exp_diff;
  logic [ExpBits-1:0] shamt;
  logic [ManBits:0]   big_sig;
  logic [ManBits:0]   small_sig;
  logic [2*SigW-1:0]  shifted;       // Upper half aligned, lower half shifted out
  logic               small_sticky;
  logic [SigW+1:0]    big_ext;
  logic [SigW+1:0]    small_ext;
  logic [SigW+1:0]    sum;           // {carry, hidden, fraction, G, R, S}
  logic               any_nan;
  logic               inf_inf;
  logic               special_d;
  logic               invalid_d;
  logic [W-1:0]       special_val_d;

  assign b_sign_eff = b_sign_i ^ sub_i;       // Subtract is add of negated B
  assign eff_sub    = a_sign_i ^ b_sign_eff;

  // Order by magnitude, ties keep A
  assign a_larger  = {a_exp_i, a_sig_i} >= {b_exp_i, b_sig_i};
  assign big_sign  = a_larger ? a_sign_i : b_sign_eff;
  assign big_exp   = a_larger ? a_exp_i  : b_exp_i;
  assign big_sig   = a_larger ? a_sig_i  : b_sig_i;
  assign small_exp = a_larger ? b_exp_i  : a_exp_i;
  assign small_sig = a_larger ? b_sig_i  : a_sig_i;

  assign exp_diff = big_exp - small_exp;
  assign shamt    = (exp_diff > ExpBits'(SigW)) ? ExpBits'(SigW) : exp_diff;  // Past SigW all sticky

  assign shifted      = {small_sig, 2'b00, {SigW{1'b0}}} >> shamt;
  assign small_sticky = |shifted[SigW-1:0];

  // Sticky takes part in the subtract so the borrow lands right
  assign big_ext   = {1'b0, big_sig, 2'b00, 1'b0};
  assign small_ext = {1'b0, shifted[2*SigW-1:SigW], small_sticky};
  assign sum       = eff_sub ? (big_ext - small_ext) : (big_ext + small_ext);

  // NaN and infinity handling
  always_comb begin : specials
    any_nan   = a_class_i.is_nan | b_class_i.is_nan;
    inf_inf   = a_class_i.is_inf & b_class_i.is_inf & eff_sub;  // inf - inf
    special_d = any_nan | a_class_i.is_inf | b_class_i.is_inf;
    invalid_d = a_class_i.is_snan | b_class_i.is_snan | inf_inf;
    if (any_nan || inf_inf) begin
      special_val_d = QNanWide[W-1:0];  // Canonical quiet NaN
    end else if (a_class_i.is_inf) begin
      special_val_d = {a_sign_i, {ExpBits{1'b1}}, {ManBits{1'b0}}};
    end else begin
      special_val_d = {b_sign_eff, {ExpBits{1'b1}}, {ManBits{1'b0}}};
    end
  end

  // Stage 1 register
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sum_o.valid         <= 1'b0;
      sum_o.sign          <= 1'b0;
      sum_o.exponent      <= '0;
      sum_o.significand   <= '0;
      sum_o.sticky        <= 1'b0;
      sum_o.eff_sub       <= 1'b0;
      sum_o.special       <= 1'b0;
      sum_o.special_value <= '0;
      sum_o.invalid       <= 1'b0;
      sum_o.rnd_mode      <= RNE;
    end else begin
      sum_o.valid         <= valid_i;
      sum_o.sign          <= big_sign;
      sum_o.exponent      <= $signed({2'b00, big_exp});
      sum_o.significand   <= sum[SigW+1:1];
      sum_o.sticky        <= sum[0];
      sum_o.eff_sub       <= eff_sub;
      sum_o.special       <= special_d;
      sum_o.special_value <= special_val_d;
      sum_o.invalid       <= invalid_d;
      sum_o.rnd_mode      <= rnd_mode_i;
    end
  end

  // Encodings above RMM are undefined
  legal_rnd_mode: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_i |-> rnd_mode_i inside {RNE, RTZ, RDN, RUP, RMM});

endmodule

`default_nettype wire

// File: design/fpadd_normalize.sv
// Stage 2 normalization
`default_nettype none

module fpadd_normalize #(
  parameter int unsigned ExpBits = fpadd_pkg::EXP_BITS,
  parameter int unsigned ManBits = fpadd_pkg::MAN_BITS
) (
  fpadd_sum_if.dst                   sum_i,
  output logic [ExpBits+ManBits-1:0] abs_value_o,          // {exponent, fraction}
  output logic [1:0]                 round_sticky_bits_o,  // {R, S}
  output logic                       sign_o,
  output logic                       eff_sub_o,
  output logic                       tiny_o
);

  localparam int unsigned SigW = ManBits + 3;  // Bits below the carry
  localparam int unsigned ExpW = ExpBits + 2;
  localparam int unsigned LzW  = $clog2(SigW + 1);
  localparam logic signed [ExpW-1:0] ExpInf = ExpW'((2 ** ExpBits) - 1);

  logic                   carry;
  logic [SigW-1:0]        sig_low;
  logic [LzW-1:0]         lz_cnt;
  logic signed [ExpW-1:0] lz_ext;
  logic signed [ExpW-1:0] exp_m1;      // Room left above exponent 1
  logic signed [ExpW-1:0] shamt;
  logic signed [ExpW-1:0] exp_norm;
  logic [SigW-1:0]        sig_shifted;
  logic                   hidden;
  logic [ManBits-1:0]     frac;
  logic                   round_bit;
  logic                   sticky_bit;

  assign carry   = sum_i.significand[SigW];
  assign sig_low = sum_i.significand[SigW-1:0];

  // Leading zero count, highest set bit wins last
  always_comb begin : lzc
    lz_cnt = LzW'(SigW);  // All zero
    for (int i = 0; i < SigW; i++) begin
      if (sig_low[i]) begin
        lz_cnt = LzW'(SigW - 1 - i);
      end
    end
  end

  // Left shift stops at exponent 1, leaving a subnormal
  assign lz_ext      = ExpW'(lz_cnt);
  assign exp_m1      = sum_i.exponent - ExpW'(1);
  assign shamt       = (lz_ext > exp_m1) ? exp_m1 : lz_ext;
  assign sig_shifted = sig_low << shamt;

  always_comb begin : shift_select
    if (carry) begin                           // Carry out, shift right by one
      hidden     = 1'b1;
      frac       = sum_i.significand[ManBits+2:3];
      round_bit  = sum_i.significand[2];
      sticky_bit = |sum_i.significand[1:0] | sum_i.sticky;
      exp_norm   = sum_i.exponent + ExpW'(1);
    end else begin
      hidden     = sig_shifted[SigW-1];        // Clear means subnormal
      frac       = sig_shifted[SigW-2:2];
      round_bit  = sig_shifted[1];
      sticky_bit = sig_shifted[0] | sum_i.sticky;
      exp_norm   = sum_i.exponent - shamt;
    end
  end

  // Pack the magnitude, saturate past the largest exponent
  always_comb begin : assemble
    if (exp_norm >= ExpInf) begin
      abs_value_o = {{ExpBits{1'b1}}, {ManBits{1'b0}}};  // Caught as overflow later
    end else if (hidden) begin
      abs_value_o = {exp_norm[ExpBits-1:0], frac};
    end else begin
      abs_value_o = {{ExpBits{1'b0}}, frac};
    end
  end

  assign round_sticky_bits_o = {round_bit, sticky_bit};
  assign sign_o              = sum_i.sign;
  assign eff_sub_o           = sum_i.eff_sub;
  assign tiny_o              = (abs_value_o[ExpBits+ManBits-1:ManBits] == '0);  // Before rounding

endmodule

`default_nettype wire

// File: design/fpadd_rounding.sv
// Mode-dependent rounding
`default_nettype none

module fpadd_rounding #(
  parameter int unsigned AbsWidth = fpadd_pkg::EXP_BITS + fpadd_pkg::MAN_BITS
) (
  input  logic [AbsWidth-1:0]   abs_value_i,              // Magnitude, no sign
  input  logic                  sign_i,
  input  logic [1:0]            round_sticky_bits_i,      // {R, S}
  input  fpadd_pkg::roundmode_e rnd_mode_i,
  input  logic                  effective_subtraction_i,
  output logic [AbsWidth-1:0]   abs_rounded_o,
  output logic                  sign_o,
  output logic                  exact_zero_o
);
  import fpadd_pkg::*;

  logic round_up;
  logic inexact;

  assign inexact = |round_sticky_bits_i;

  always_comb begin : decide
    unique case (rnd_mode_i)
      RNE: begin
        unique case (round_sticky_bits_i)
          2'b10:   round_up = abs_value_i[0];  // Tie, go to even
          2'b11:   round_up = 1'b1;            // Above half
          default: round_up = 1'b0;            // Below half
        endcase
      end
      RTZ:     round_up = 1'b0;                          // Truncate
      RDN:     round_up = inexact & sign_i;              // Away only when negative
      RUP:     round_up = inexact & ~sign_i;             // Away only when positive
      RMM:     round_up = round_sticky_bits_i[1];        // Half or more goes away
      default: round_up = 1'b0;
    endcase
  end

  // Carry out of the fraction bumps the exponent
  assign abs_rounded_o = abs_value_i + AbsWidth'(round_up);

  assign exact_zero_o = (abs_value_i == '0) && !inexact;

  // x - x is +0, except -0 toward -inf
  assign sign_o = (exact_zero_o && effective_subtraction_i) ? (rnd_mode_i == RDN) : sign_i;

endmodule

`default_nettype wire

// File: design/fpadd_result.sv
// Stage 2 result select and flags
`default_nettype none

module fpadd_result #(
  parameter int unsigned ExpBits = fpadd_pkg::EXP_BITS,
  parameter int unsigned ManBits = fpadd_pkg::MAN_BITS
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  fpadd_sum_if.dst                   sum_i,
  input  logic [ExpBits+ManBits-1:0] abs_rounded_i,
  input  logic                       sign_i,
  input  logic                       exact_zero_i,
  input  logic [1:0]                 round_sticky_bits_i,
  input  logic                       tiny_i,
  output logic                       valid_o,
  output logic [ExpBits+ManBits:0]   result_o,
  output fpadd_pkg::status_t         status_o
);
  import fpadd_pkg::*;

  localparam int unsigned AbsW = ExpBits + ManBits;
  localparam logic [ExpBits-1:0] MaxExp = ExpBits'(2 * bias(ExpBits));  // Largest finite field

  logic          overflow;
  logic          to_inf;
  logic          inexact;
  logic [AbsW:0] result_d;
  status_t       status_d;

  assign overflow = &abs_rounded_i[AbsW-1:ManBits];  // Exponent reached all ones
  assign inexact  = |round_sticky_bits_i;

  // Overflow target per mode and sign
  always_comb begin : overflow_target
    unique case (sum_i.rnd_mode)
      RTZ:     to_inf = 1'b0;
      RDN:     to_inf = sign_i;
      RUP:     to_inf = ~sign_i;
      default: to_inf = 1'b1;  // RNE, RMM
    endcase
  end

  always_comb begin : select
    status_d = '0;
    if (sum_i.special) begin
      result_d    = sum_i.special_value;  // NaN or infinity, never inexact
      status_d.nv = sum_i.invalid;
    end else if (overflow) begin
      if (to_inf) begin
        result_d = {sign_i, {ExpBits{1'b1}}, {ManBits{1'b0}}};
      end else begin
        result_d = {sign_i, MaxExp, {ManBits{1'b1}}};
      end
      status_d.of = 1'b1;
      status_d.nx = 1'b1;
    end else begin
      result_d    = exact_zero_i ? {sign_i, {AbsW{1'b0}}} : {sign_i, abs_rounded_i};
      status_d.uf = tiny_i & inexact;     // Tiny before rounding
      status_d.nx = inexact;
    end
  end

  // Stage 2 register
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_o  <= 1'b0;
      result_o <= '0;
      status_o <= '0;
    end else begin
      valid_o  <= sum_i.valid;
      result_o <= result_d;
      status_o <= status_d;
    end
  end

  // Overflow is always inexact
  overflow_flags: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    status_o.of |-> status_o.nx);

endmodule

`default_nettype wire

// File: design/fpadd_top.sv
// Pipelined floating-point adder
`default_nettype none

module fpadd_top #(
  parameter int unsigned ExpBits = fpadd_pkg::EXP_BITS,
  parameter int unsigned ManBits = fpadd_pkg::MAN_BITS
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     valid_i,
  input  logic [ExpBits+ManBits:0] op_a_i,
  input  logic [ExpBits+ManBits:0] op_b_i,
  input  logic                     sub_i,       // 1 gives A - B
  input  fpadd_pkg::roundmode_e    rnd_mode_i,
  output logic                     valid_o,     // Two cycles after valid_i
  output logic [ExpBits+ManBits:0] result_o,
  output logic [3:0]               status_o     // {NV, OF, UF, NX}
);
  import fpadd_pkg::*;

  localparam int unsigned AbsWidth = ExpBits + ManBits;

  logic                a_sign;
  logic [ExpBits-1:0]  a_exp;
  logic [ManBits:0]    a_sig;
  fp_class_t           a_class;
  logic                b_sign;
  logic [ExpBits-1:0]  b_exp;
  logic [ManBits:0]    b_sig;
  fp_class_t           b_class;
  logic [AbsWidth-1:0] abs_value;
  logic [AbsWidth-1:0] abs_rounded;
  logic [1:0]          rs_bits;
  logic                norm_sign;
  logic                eff_sub;
  logic                tiny;
  logic                rnd_sign;
  logic                exact_zero;

  fpadd_sum_if #(.ExpBits(ExpBits), .ManBits(ManBits)) sum_if ();

  fpadd_classify #(.ExpBits(ExpBits), .ManBits(ManBits)) u_class_a (
    .operand_i     (op_a_i),
    .sign_o        (a_sign),
    .exponent_o    (a_exp),
    .significand_o (a_sig),
    .class_o       (a_class)
  );

  fpadd_classify #(.ExpBits(ExpBits), .ManBits(ManBits)) u_class_b (
    .operand_i     (op_b_i),
    .sign_o        (b_sign),
    .exponent_o    (b_exp),
    .significand_o (b_sig),
    .class_o       (b_class)
  );

  // Stage 1
  fpadd_align_add #(.ExpBits(ExpBits), .ManBits(ManBits)) u_align_add (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .valid_i    (valid_i),
    .sub_i      (sub_i),
    .rnd_mode_i (rnd_mode_i),
    .a_sign_i   (a_sign),
    .a_exp_i    (a_exp),
    .a_sig_i    (a_sig),
    .a_class_i  (a_class),
    .b_sign_i   (b_sign),
    .b_exp_i    (b_exp),
    .b_sig_i    (b_sig),
    .b_class_i  (b_class),
    .sum_o      (sum_if.src)
  );

  // Stage 2, combinational part
  fpadd_normalize #(.ExpBits(ExpBits), .ManBits(ManBits)) u_normalize (
    .sum_i               (sum_if.dst),
    .abs_value_o         (abs_value),
    .round_sticky_bits_o (rs_bits),
    .sign_o              (norm_sign),
    .eff_sub_o           (eff_sub),
    .tiny_o              (tiny)
  );

  fpadd_rounding #(.AbsWidth(AbsWidth)) u_rounding (
    .abs_value_i             (abs_value),
    .sign_i                  (norm_sign),
    .round_sticky_bits_i     (rs_bits),
    .rnd_mode_i              (sum_if.rnd_mode),
    .effective_subtraction_i (eff_sub),
    .abs_rounded_o           (abs_rounded),
    .sign_o                  (rnd_sign),
    .exact_zero_o            (exact_zero)
  );

  // Stage 2 register and flags
  fpadd_result #(.ExpBits(ExpBits), .ManBits(ManBits)) u_result (
    .clk_i               (clk_i),
    .rst_n_i             (rst_n_i),
    .sum_i               (sum_if.dst),
    .abs_rounded_i       (abs_rounded),
    .sign_i              (rnd_sign),
    .exact_zero_i        (exact_zero),
    .round_sticky_bits_i (rs_bits),
    .tiny_i              (tiny),
    .valid_o             (valid_o),
    .result_o            (result_o),
    .status_o            (status_o)
  );

endmodule

`default_nettype wire

// File: sim/fpadd_tb.sv
// Floating-point adder testbench
`default_nettype none

module fpadd_tb;
  import fpadd_pkg::*;

  localparam int ClkHalf    = 20;   // 40 time unit period
  localparam int ResetCyc   = 4;
  localparam int DrainLimit = 10;   // Cycles allowed for the last results

  // Expected status values, {NV, OF, UF, NX}
  localparam status_t StNone = status_t'(4'b0000);
  localparam status_t StNx   = status_t'(4'b0001);
  localparam status_t StOfNx = status_t'(4'b0101);
  localparam status_t StNv   = status_t'(4'b1000);

  typedef struct packed {
    logic [31:0] a;
    logic [31:0] b;
    logic        sub;
    roundmode_e  mode;
    logic [31:0] res;    // Expected binary32 result
    status_t     st;     // Expected flags
  } entry_t;

  typedef struct packed {
    logic [31:0] res;
    status_t     st;
    logic [31:0] cycle;  // Cycle count at issue
    logic [15:0] idx;
  } pending_t;

  logic        clk;
  logic        rst_n;
  logic        valid_in;
  logic [31:0] op_a;
  logic [31:0] op_b;
  logic        sub;
  roundmode_e  rnd_mode;
  logic        valid_out;
  logic [31:0] result;
  logic [3:0]  status;

  logic [31:0] cycle_cnt = '0;
  entry_t      table_q[$];      // Stimulus table
  pending_t    pend_q[$];       // Results still in flight

  fpadd_top #(.ExpBits(EXP_BITS), .ManBits(MAN_BITS)) u_dut (
    .clk_i      (clk),
    .rst_n_i    (rst_n),
    .valid_i    (valid_in),
    .op_a_i     (op_a),
    .op_b_i     (op_b),
    .sub_i      (sub),
    .rnd_mode_i (rnd_mode),
    .valid_o    (valid_out),
    .result_o   (result),
    .status_o   (status)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #ClkHalf clk = ~clk;
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 32'd1;  // Rising edges seen so far

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic add_entry(input logic [31:0] a, input logic [31:0] b, input logic sub_op,
                           input roundmode_e mode, input logic [31:0] res, input status_t st);
    entry_t e;
    e.a    = a;
    e.b    = b;
    e.sub  = sub_op;
    e.mode = mode;
    e.res  = res;
    e.st   = st;
    table_q.push_back(e);
  endtask

  task automatic check_result(input logic [31:0] got, input logic [31:0] exp, input int idx);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0t: result_o = %h, expected %h (entry %0d)",
                          $time, got, exp, idx));
    end
  endtask

  task automatic check_status(input status_t got, input status_t exp, input int idx);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0t: status_o = %b, expected %b (entry %0d)",
                          $time, got, exp, idx));
    end
  endtask

  // Sampled on the falling edge, away from the register updates
  always @(negedge clk) begin : monitor
    pending_t exp_e;
    if (rst_n) begin
      if (valid_out) begin
        if (pend_q.size() == 0) begin
          abort_run("valid_o went high with no operation outstanding");
        end else begin
          exp_e = pend_q.pop_front();
          if (cycle_cnt != exp_e.cycle + 32'd2) begin
            abort_run($sformatf("Result of entry %0d came %0d cycles after issue, not 2",
                                exp_e.idx, cycle_cnt - exp_e.cycle));
          end
          check_result(result, exp_e.res, int'(exp_e.idx));
          check_status(status_t'(status), exp_e.st, int'(exp_e.idx));
        end
      end else if (pend_q.size() != 0 && cycle_cnt >= pend_q[0].cycle + 32'd2) begin
        abort_run($sformatf("valid_o missing two cycles after issue of entry %0d",
                            pend_q[0].idx));
      end
    end
  end

  initial begin : stimulus
    pending_t p;
    int       wait_cnt;

    // All DUT inputs idle, reset held
    rst_n    = 1'b0;
    valid_in = 1'b0;
    op_a     = '0;
    op_b     = '0;
    sub      = 1'b0;
    rnd_mode = RNE;

    // Ordinary sums, RNE
    add_entry(32'h3F800000, 32'h40000000, 1'b0, RNE, 32'h40400000, StNone);  // 1 + 2 exact
    add_entry(32'h3F800000, 32'h33800000, 1'b0, RNE, 32'h3F800000, StNx);    // Tie, even stays
    add_entry(32'h3F800001, 32'h33800000, 1'b0, RNE, 32'h3F800002, StNx);    // Tie, odd goes up
    add_entry(32'h40400000, 32'h3F800000, 1'b1, RNE, 32'h40000000, StNone);  // 3 - 1
    add_entry(32'h3F800000, 32'h40000000, 1'b1, RNE, 32'hBF800000, StNone);  // 1 - 2 negative
    add_entry(32'h3F800000, 32'h00000001, 1'b0, RNE, 32'h3F800000, StNx);    // Far below ulp
    // -1 - 2^-24 is a tie with even LSB, every mode
    add_entry(32'hBF800000, 32'h33800000, 1'b1, RNE, 32'hBF800000, StNx);
    add_entry(32'hBF800000, 32'h33800000, 1'b1, RTZ, 32'hBF800000, StNx);
    add_entry(32'hBF800000, 32'h33800000, 1'b1, RDN, 32'hBF800001, StNx);
    add_entry(32'hBF800000, 32'h33800000, 1'b1, RUP, 32'hBF800000, StNx);
    add_entry(32'hBF800000, 32'h33800000, 1'b1, RMM, 32'hBF800001, StNx);
    add_entry(32'h3F800000, 32'h33C00000, 1'b0, RTZ, 32'h3F800000, StNx);    // 0.75 ulp above
    add_entry(32'h3F800000, 32'h33C00000, 1'b0, RUP, 32'h3F800001, StNx);
    // Exact cancellation
    add_entry(32'h3FC00000, 32'h3FC00000, 1'b1, RNE, 32'h00000000, StNone);
    add_entry(32'h3FC00000, 32'h3FC00000, 1'b1, RTZ, 32'h00000000, StNone);
    add_entry(32'h3FC00000, 32'h3FC00000, 1'b1, RDN, 32'h80000000, StNone);  // Only -0 case
    add_entry(32'h3FC00000, 32'h3FC00000, 1'b1, RUP, 32'h00000000, StNone);
    add_entry(32'h3FC00000, 32'h3FC00000, 1'b1, RMM, 32'h00000000, StNone);
    add_entry(32'h40A00000, 32'hC0A00000, 1'b0, RDN, 32'h80000000, StNone);  // x + (-x)
    // Overflow, max + max and rounding past max
    add_entry(32'h7F7FFFFF, 32'h7F7FFFFF, 1'b0, RNE, 32'h7F800000, StOfNx);
    add_entry(32'h7F7FFFFF, 32'h7F7FFFFF, 1'b0, RUP, 32'h7F800000, StOfNx);
    add_entry(32'h7F7FFFFF, 32'h7F7FFFFF, 1'b0, RTZ, 32'h7F7FFFFF, StOfNx);
    add_entry(32'h7F7FFFFF, 32'h7F7FFFFF, 1'b0, RDN, 32'h7F7FFFFF, StOfNx);
    add_entry(32'h7F7FFFFF, 32'h7F000000, 1'b0, RNE, 32'h7F800000, StOfNx);
    add_entry(32'hFF7FFFFF, 32'hFF7FFFFF, 1'b0, RDN, 32'hFF800000, StOfNx);
    add_entry(32'hFF7FFFFF, 32'hFF7FFFFF, 1'b0, RUP, 32'hFF7FFFFF, StOfNx);
    add_entry(32'h7F7FFFFF, 32'h73000000, 1'b0, RNE, 32'h7F800000, StOfNx);  // Half ulp, odd
    add_entry(32'h7F7FFFFF, 32'h73000000, 1'b0, RTZ, 32'h7F7FFFFF, StNx);    // Truncates to max
    // Subnormal range, sums there are always exact
    add_entry(32'h00000001, 32'h00000002, 1'b0, RNE, 32'h00000003, StNone);
    add_entry(32'h00C00000, 32'h00800000, 1'b1, RNE, 32'h00400000, StNone);  // Normals to subnormal
    add_entry(32'h80000005, 32'h00000003, 1'b0, RNE, 32'h80000002, StNone);
    add_entry(32'h007FFFFF, 32'h00000001, 1'b0, RNE, 32'h00800000, StNone);  // Into normal range
    // Infinities and NaNs
    add_entry(32'h7F800000, 32'hFF800000, 1'b0, RNE, 32'h7FC00000, StNv);    // inf + -inf
    add_entry(32'h7F800000, 32'h7F800000, 1'b1, RNE, 32'h7FC00000, StNv);    // inf - inf
    add_entry(32'h7F800001, 32'h3F800000, 1'b0, RNE, 32'h7FC00000, StNv);    // sNaN in A
    add_entry(32'h3F800000, 32'hFFA00000, 1'b0, RNE, 32'h7FC00000, StNv);    // sNaN in B
    add_entry(32'h7FC00000, 32'h3F800000, 1'b0, RNE, 32'h7FC00000, StNone);  // qNaN quiet
    add_entry(32'h7F800000, 32'h3F800000, 1'b0, RNE, 32'h7F800000, StNone);
    add_entry(32'h3F800000, 32'h7F800000, 1'b1, RNE, 32'hFF800000, StNone);  // 1 - inf
    add_entry(32'hFF800000, 32'h7F7FFFFF, 1'b0, RTZ, 32'hFF800000, StNone);

    repeat (ResetCyc) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    if (valid_out !== 1'b0) begin
      abort_run("valid_o is not low after reset");
    end

    // Back to back, one valid pulse per entry
    foreach (table_q[i]) begin
      valid_in = 1'b1;
      op_a     = table_q[i].a;
      op_b     = table_q[i].b;
      sub      = table_q[i].sub;
      rnd_mode = table_q[i].mode;
      p.res    = table_q[i].res;
      p.st     = table_q[i].st;
      p.cycle  = cycle_cnt;
      p.idx    = 16'(i);
      pend_q.push_back(p);
      @(negedge clk);
    end
    valid_in = 1'b0;

    wait_cnt = 0;
    while (pend_q.size() != 0 && wait_cnt < DrainLimit) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (pend_q.size() != 0) begin
      abort_run("Timed out waiting for the outstanding results");
    end
    repeat (3) @(negedge clk);  // Catches a stray valid_o

    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
design/fpadd_pkg.sv
design/fpadd_sum_if.sv
design/fpadd_classify.sv
design/fpadd_align_add.sv
design/fpadd_normalize.sv
design/fpadd_rounding.sv
design/fpadd_result.sv
design/fpadd_top.sv
sim/fpadd_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the adder testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module fpadd_tb \
  -Mdir obj_dir -o fpadd_sim > build.log 2>&1 \
  || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/fpadd_sim > sim.log 2>&1
grep -q "^Simulation PASSED$" sim.log && echo "PASS" \
  || { echo "FAIL, see sim.log"; exit 1; }
